// File: bench/mci_tb_tests.svh
// MCI directed tests
`ifndef MCI_TB_TESTS_SVH
`define MCI_TB_TESTS_SVH

task automatic test_reset_outputs();
    check_bit("resp_valid_o in reset", resp_valid_o, 1'b0);
    check_bit("lc_init_o in reset", lc_init_o, 1'b0);
    check_bit("fc_opt_init_o in reset", fc_opt_init_o, 1'b0);
    check_bit("nmi_intr_o in reset", nmi_intr_o, 1'b0);
    check_bit("mci_intr_o in reset", mci_intr_o, 1'b0);
    check_bit("all_error_fatal_o in reset", all_error_fatal_o, 1'b0);
    check_bit("all_error_non_fatal_o in reset", all_error_non_fatal_o, 1'b0);
    check_bit("cptra_rst_b_o in reset", cptra_rst_b_o, 1'b0);
    check_bit("mcu_rst_b_o in reset", mcu_rst_b_o, 1'b0);
    check_state("boot_fsm_o in reset", boot_fsm_o, BOOT_RESET);
endtask

task automatic test_reg_access();
    mci_resp_t   resp;
    logic [31:0] data;
    data = $random(seed);
    issue_request(MCU_USER, `MCI_REG_GENERIC_OUT, 1'b1, data, resp);
    check_resp("GENERIC_OUT write", resp, {32'h0, 1'b0});
    issue_request(MCU_USER, `MCI_REG_GENERIC_OUT, 1'b0, '0, resp);
    check_resp("GENERIC_OUT read", resp, {data, 1'b0});
    check_word("generic_out_o", generic_out_o, data);
    issue_request(DEBUG_USER, `MCI_REG_RESET_VECTOR, 1'b0, '0, resp);
    check_resp("RESET_VECTOR strap value", resp, {VECTOR_STRAP, 1'b0});
    check_word("mcu_reset_vector_o", mcu_reset_vector_o, VECTOR_STRAP);
endtask

task automatic test_access_errors();
    mci_resp_t   resp;
    logic [31:0] data;
    data = $random(seed);
    issue_request(MCU_USER, `MCI_REG_GENERIC_OUT, 1'b1, data, resp);
    issue_request(BAD_USER, `MCI_REG_GENERIC_OUT, 1'b1, ~data, resp);
    check_resp("unknown user write", resp, {32'h0, 1'b1});
    issue_request(BAD_USER, `MCI_REG_GENERIC_OUT, 1'b0, '0, resp);
    check_resp("unknown user read", resp, {32'h0, 1'b1});
    issue_request(MCU_USER, 32'h0000_0024, 1'b0, '0, resp);
    check_resp("unmapped read", resp, {32'h0, 1'b1});
    issue_request(MCU_USER, 32'h0000_0100, 1'b1, ~data, resp);
    check_resp("unmapped write", resp, {32'h0, 1'b1});
    issue_request(CPTRA_USER, `MCI_REG_WDT_EN, 1'b1, 32'h1, resp);
    check_resp("cptra WDT_EN write", resp, {32'h0, 1'b1});
    issue_request(MCU_USER, `MCI_REG_GENERIC_OUT, 1'b0, '0, resp);
    check_resp("GENERIC_OUT after denied write", resp, {data, 1'b0});
    // Caliptra keeps read access
    issue_request(CPTRA_USER, `MCI_REG_WDT_EN, 1'b0, '0, resp);
    check_resp("WDT_EN after denied write", resp, {32'h0, 1'b0});
endtask

task automatic test_error_aggregation();
    mci_resp_t   resp;
    logic [31:0] fatal;
    logic [31:0] non_fatal;
    logic [31:0] lowest;
    fatal     = $random(seed);
    non_fatal = $random(seed);
    if (fatal == '0)
        fatal = 32'h1;
    if (non_fatal == '0)
        non_fatal = 32'h1;
    lowest = fatal & (~fatal + 32'h1);
    issue_request(MCU_USER, `MCI_REG_ERROR_FATAL_MASK, 1'b1, fatal, resp);
    check_resp("fatal mask write", resp, {32'h0, 1'b0});
    @(posedge clk);
    agg_error_fatal_i <= fatal;
    @(negedge clk);
    @(negedge clk);
    check_bit("all_error_fatal_o fully masked", all_error_fatal_o, 1'b0);
    // Mask takes effect at the accepting edge and reaches the output one edge later
    issue_request(MCU_USER, `MCI_REG_ERROR_FATAL_MASK, 1'b1, fatal & ~lowest, resp);
    @(negedge clk);
    check_bit("all_error_fatal_o one bit unmasked", all_error_fatal_o, 1'b1);
    @(posedge clk);
    agg_error_non_fatal_i <= non_fatal;
    @(negedge clk);
    check_bit("all_error_non_fatal_o before capture", all_error_non_fatal_o, 1'b0);
    @(negedge clk);
    check_bit("all_error_non_fatal_o one cycle later", all_error_non_fatal_o, 1'b1);
    @(posedge clk);
    agg_error_fatal_i     <= '0;
    agg_error_non_fatal_i <= '0;
endtask

task automatic test_boot_sequence();
    mci_resp_t resp;
    int        low_cycles;
    repeat (4) begin
        @(negedge clk);
        check_bit("lc_init_o while lc_done_i low", lc_init_o, 1'b1);
        check_bit("cptra_rst_b_o during lc init", cptra_rst_b_o, 1'b0);
        check_state("boot_fsm_o during lc init", boot_fsm_o, BOOT_LCC_INIT);
    end
    @(posedge clk);
    lc_done_i <= 1'b1;
    wait_for_level(SIG_LC_INIT, 1'b0, 8, "lc_init_o to drop");
    @(posedge clk);
    lc_done_i <= 1'b0;
    repeat (4) begin
        @(negedge clk);
        check_bit("fc_opt_init_o while fc_opt_done_i low", fc_opt_init_o, 1'b1);
        check_state("boot_fsm_o during fuse init", boot_fsm_o, BOOT_FUSE_INIT);
    end
    @(posedge clk);
    fc_opt_done_i <= 1'b1;
    wait_for_level(SIG_FC_OPT_INIT, 1'b0, 8, "fc_opt_init_o to drop");
    wait_for_level(SIG_CPTRA_RST_B, 1'b1, 8, "cptra_rst_b_o release");
    check_state("boot_fsm_o waiting for BOOT_GO", boot_fsm_o, BOOT_WAIT_GO);
    @(posedge clk);
    fc_opt_done_i <= 1'b0;
    repeat (6) begin
        @(negedge clk);
        check_bit("mcu_rst_b_o before BOOT_GO", mcu_rst_b_o, 1'b0);
    end
    issue_request(CPTRA_USER, `MCI_REG_BOOT_GO, 1'b1, 32'h1, resp);
    check_resp("cptra BOOT_GO write", resp, {32'h0, 1'b0});
    wait_for_level(SIG_MCU_RST_B, 1'b1, 8, "mcu_rst_b_o release");
    check_state("boot_fsm_o after BOOT_GO", boot_fsm_o, BOOT_RUN);
    issue_request(MCU_USER, `MCI_REG_RESET_REQUEST, 1'b1, 32'h1, resp);
    check_resp("RESET_REQUEST write", resp, {32'h0, 1'b0});
    // Pulse starts at the accepting edge, so it is already low here
    low_cycles = 0;
    while (mcu_rst_b_o === 1'b0 && low_cycles < 64) begin
        low_cycles++;
        @(negedge clk);
    end
    check_word("mcu_rst_b_o low cycles", 32'(low_cycles), `MCI_MCU_RST_CYCLES);
endtask

task automatic test_watchdog();
    mci_resp_t resp;
    issue_request(MCU_USER, `MCI_REG_WDT_PERIOD, 1'b1, 32'd20, resp);
    check_resp("WDT_PERIOD write", resp, {32'h0, 1'b0});
    issue_request(MCU_USER, `MCI_REG_WDT_EN, 1'b1, 32'h1, resp);
    check_resp("WDT_EN write", resp, {32'h0, 1'b0});
    wait_for_level(SIG_MCI_INTR, 1'b1, 20 + 10, "first watchdog timeout");
    check_bit("nmi_intr_o after first timeout", nmi_intr_o, 1'b0);
    issue_request(MCU_USER, `MCI_REG_INTR_STATUS, 1'b1, 32'h1, resp);
    check_resp("INTR_STATUS clear", resp, {32'h0, 1'b0});
    check_bit("mci_intr_o after clear", mci_intr_o, 1'b0);
    // Without a restart the next expiry escalates
    wait_for_level(SIG_NMI_INTR, 1'b1, 20 + 10, "NMI after unserviced timeout");
endtask

`endif

// File: bench/mci_tb.sv
// MCI register slice testbench
`include "mci_defs.svh"

module mci_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mci_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    // Worst case cycles of each test in run order
    localparam int TEST_CYCLES   = 20 + 40 + 30 + 120 + 90;
    localparam int MARGIN_CYCLES = 100;

    localparam logic [31:0] MCU_USER     = 32'h0000_1001;
    localparam logic [31:0] CPTRA_USER   = 32'h0000_2002;
    localparam logic [31:0] DEBUG_USER   = 32'h0000_3003;
    localparam logic [31:0] BAD_USER     = 32'hdead_0000;
    localparam logic [31:0] VECTOR_STRAP = 32'h8000_0400;

    typedef enum {
        SIG_LC_INIT,
        SIG_FC_OPT_INIT,
        SIG_CPTRA_RST_B,
        SIG_MCU_RST_B,
        SIG_MCI_INTR,
        SIG_NMI_INTR
    } watch_sig_e;

    logic                   clk = 1'b0;
    logic                   rst_n_i;
    logic                   req_dv_i;
    mci_req_t               req_i;
    mci_straps_t            straps_i;
    logic [`MCI_DATA_W-1:0] strap_reset_vector_i;
    logic                   resp_valid_o;
    mci_resp_t              resp_o;
    logic                   lc_done_i;
    logic                   lc_init_o;
    logic                   fc_opt_done_i;
    logic                   fc_opt_init_o;
    logic                   cptra_rst_b_o;
    logic                   mcu_rst_b_o;
    mci_boot_e              boot_fsm_o;
    logic                   nmi_intr_o;
    logic                   mci_intr_o;
    logic [31:0]            agg_error_fatal_i;
    logic [31:0]            agg_error_non_fatal_i;
    logic                   all_error_fatal_o;
    logic                   all_error_non_fatal_o;
    logic [31:0]            generic_out_o;
    logic [`MCI_DATA_W-1:0] mcu_reset_vector_o;

    int     error_count   = 0;
    int     timeout_count = 0;
    integer seed          = 20;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mci_top dut (.*);

    task automatic check_resp(input string what, input mci_resp_t got, input mci_resp_t exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR @ %0t: %s got data %h err %b, expected data %h err %b",
                     $time, what, got.rdata, got.error, exp.rdata, exp.error);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR @ %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR @ %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_state(input string what, input mci_boot_e got,
                               input mci_boot_e exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR @ %0t: %s got state %0d, expected state %0d",
                     $time, what, got, exp);
        end
    endtask

    function automatic logic sample_output(input watch_sig_e sig);
        case (sig)
            SIG_LC_INIT:     return lc_init_o;
            SIG_FC_OPT_INIT: return fc_opt_init_o;
            SIG_CPTRA_RST_B: return cptra_rst_b_o;
            SIG_MCU_RST_B:   return mcu_rst_b_o;
            SIG_MCI_INTR:    return mci_intr_o;
            default:         return nmi_intr_o;
        endcase
    endfunction

    // Steps from negedge to negedge until the output reaches the level
    task automatic wait_for_level(input watch_sig_e sig, input logic level,
                                  input int max_cycles, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (sample_output(sig) !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (sample_output(sig) !== level) begin
            timeout_count++;
            $display("Timed out after %0d cycles waiting for %s", max_cycles, what);
        end
    endtask

    // One request that returns at the negedge where the response is stable
    task automatic issue_request(input logic [31:0] user, input logic [31:0] addr,
                                 input logic write, input logic [31:0] wdata,
                                 output mci_resp_t resp);
        int waited;
        waited = 0;
        @(posedge clk);
        req_dv_i    <= 1'b1;
        req_i.addr  <= addr;
        req_i.wdata <= wdata;
        req_i.user  <= user;
        req_i.write <= write;
        @(posedge clk);
        req_dv_i <= 1'b0;
        @(negedge clk);
        while (!resp_valid_o && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!resp_valid_o) begin
            timeout_count++;
            $display("No response arrived for the request to address %h", addr);
        end
        check_word("response latency in cycles", 32'(waited + 1), 32'd1);
        resp = resp_o;
    endtask

    `include "mci_tb_tests.svh"

    initial begin
        rst_n_i                = 1'b0;
        req_dv_i               = 1'b0;
        req_i                  = '0;
        straps_i.mcu_user      = MCU_USER;
        straps_i.cptra_user    = CPTRA_USER;
        straps_i.debug_user    = DEBUG_USER;
        strap_reset_vector_i   = VECTOR_STRAP;
        lc_done_i              = 1'b0;
        fc_opt_done_i          = 1'b0;
        agg_error_fatal_i      = '0;
        agg_error_non_fatal_i  = '0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        test_reset_outputs();
        @(posedge clk);
        rst_n_i <= 1'b1;
        test_reg_access();
        test_access_errors();
        test_error_aggregation();
        test_boot_sequence();
        test_watchdog();
        $display("Run complete with %0d errors and %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Run watchdog
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Simulation did not finish within its cycle budget, stopping");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: hdl/mci_boot_seqr.sv
// MCI boot sequencer
`include "mci_defs.svh"

module mci_boot_seqr (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               lc_done_i,
    input  logic               fc_opt_done_i,
    input  logic               boot_go_i,
    input  logic               mcu_rst_req_i,
    output logic               lc_init_o,
    output logic               fc_opt_init_o,
    output logic               cptra_rst_b_o,
    output logic               mcu_rst_b_o,
    output mci_pkg::mci_boot_e boot_fsm_o
);
    import mci_pkg::*;

    localparam int CNT_W = $clog2(`MCI_MCU_RST_CYCLES + 1);

    mci_boot_e        state_q;
    mci_boot_e        state_d;
    logic [CNT_W-1:0] rst_cnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_RESET:     state_d = BOOT_LCC_INIT;
            BOOT_LCC_INIT:  if (lc_done_i) state_d = BOOT_FUSE_INIT;
            BOOT_FUSE_INIT: if (fc_opt_done_i) state_d = BOOT_WAIT_GO;
            BOOT_WAIT_GO:   if (boot_go_i) state_d = BOOT_RUN;
            BOOT_RUN:       state_d = BOOT_RUN;
            default:        state_d = BOOT_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= BOOT_RESET;
            rst_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // MCU reset pulse holds one low cycle per count
            if ((state_q == BOOT_RUN) && mcu_rst_req_i)
                rst_cnt_q <= CNT_W'(`MCI_MCU_RST_CYCLES);
            else if (rst_cnt_q != '0)
                rst_cnt_q <= rst_cnt_q - CNT_W'(1);
        end
    end

    assign lc_init_o     = (state_q == BOOT_LCC_INIT);
    assign fc_opt_init_o = (state_q == BOOT_FUSE_INIT);
    assign cptra_rst_b_o = (state_q == BOOT_WAIT_GO) || (state_q == BOOT_RUN);
    assign mcu_rst_b_o   = (state_q == BOOT_RUN) && (rst_cnt_q == '0);
    assign boot_fsm_o    = state_q;

endmodule

// File: hdl/mci_csr_bank.sv
// MCI control and status registers
`include "mci_defs.svh"

module mci_csr_bank (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   dec_valid_i,
    input  mci_pkg::mci_dec_t      dec_i,
    input  logic [`MCI_DATA_W-1:0] strap_reset_vector_i,
    input  logic                   t1_timeout_p_i,
    output logic [`MCI_DATA_W-1:0] rdata_o,
    output logic                   err_o,
    output mci_pkg::mci_wdt_cfg_t  wdt_cfg_o,
    output logic                   boot_go_o,
    output logic                   mcu_rst_req_o,
    output logic [31:0]            fatal_mask_o,
    output logic [31:0]            generic_out_o,
    output logic [`MCI_DATA_W-1:0] mcu_reset_vector_o,
    output logic                   mci_intr_o
);
    import mci_pkg::*;

    logic                   boot_go_q;
    logic                   wdt_en_q;
    logic [31:0]            wdt_period_q;
    logic                   intr_t1_q;
    logic [31:0]            fatal_mask_q;
    logic [31:0]            generic_out_q;
    logic [`MCI_DATA_W-1:0] reset_vector_q;
    logic                   wr_en;

    assign wr_en = dec_valid_i & dec_i.write;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            boot_go_q      <= 1'b0;
            wdt_en_q       <= 1'b0;
            wdt_period_q   <= '0;
            intr_t1_q      <= 1'b0;
            fatal_mask_q   <= '0;
            generic_out_q  <= '0;
            reset_vector_q <= strap_reset_vector_i;
        end else begin
            if (wr_en) begin
                case (dec_i.idx)
                    REG_BOOT_GO:          boot_go_q      <= dec_i.wdata[0];
                    REG_WDT_EN:           wdt_en_q       <= dec_i.wdata[0];
                    REG_WDT_PERIOD:       wdt_period_q   <= dec_i.wdata;
                    REG_ERROR_FATAL_MASK: fatal_mask_q   <= dec_i.wdata;
                    REG_GENERIC_OUT:      generic_out_q  <= dec_i.wdata;
                    REG_RESET_VECTOR:     reset_vector_q <= dec_i.wdata;
                    default: ;
                endcase
            end
            // A new timeout wins over a write-1 clear in the same cycle
            if (t1_timeout_p_i)
                intr_t1_q <= 1'b1;
            else if (wr_en && (dec_i.idx == REG_INTR_STATUS) && dec_i.wdata[0])
                intr_t1_q <= 1'b0;
        end
    end

    // Read mux gives zero for errors and for the pulse registers
    always_comb begin
        rdata_o = '0;
        if (dec_valid_i && dec_i.read) begin
            case (dec_i.idx)
                REG_BOOT_GO:          rdata_o = `MCI_DATA_W'(boot_go_q);
                REG_WDT_EN:           rdata_o = `MCI_DATA_W'(wdt_en_q);
                REG_WDT_PERIOD:       rdata_o = wdt_period_q;
                REG_INTR_STATUS:      rdata_o = `MCI_DATA_W'(intr_t1_q);
                REG_ERROR_FATAL_MASK: rdata_o = fatal_mask_q;
                REG_GENERIC_OUT:      rdata_o = generic_out_q;
                REG_RESET_VECTOR:     rdata_o = reset_vector_q;
                default:              rdata_o = '0;
            endcase
        end
    end

    assign err_o = dec_valid_i & dec_i.error;

    // Restart and reset request fire in the accepting cycle
    assign wdt_cfg_o.en      = wdt_en_q;
    assign wdt_cfg_o.restart = wr_en && (dec_i.idx == REG_WDT_RESTART);
    assign wdt_cfg_o.period  = wdt_period_q;
    assign mcu_rst_req_o     = wr_en && (dec_i.idx == REG_RESET_REQUEST);

    assign boot_go_o          = boot_go_q;
    assign fatal_mask_o       = fatal_mask_q;
    assign generic_out_o      = generic_out_q;
    assign mcu_reset_vector_o = reset_vector_q;
    assign mci_intr_o         = intr_t1_q;

endmodule

// File: hdl/mci_defs.svh
// MCI width, offset and timing definitions
`ifndef MCI_DEFS_SVH
`define MCI_DEFS_SVH

// Request bus widths
`define MCI_ADDR_W 32
`define MCI_DATA_W 32
`define MCI_USER_W 32

// MCU reset pulse length after a reset request, in cycles
`define MCI_MCU_RST_CYCLES 16

// Register byte offsets
`define MCI_REG_BOOT_GO          32'h0000_0000
`define MCI_REG_RESET_REQUEST    32'h0000_0004
`define MCI_REG_WDT_EN           32'h0000_0008
`define MCI_REG_WDT_RESTART      32'h0000_000C
`define MCI_REG_WDT_PERIOD       32'h0000_0010
`define MCI_REG_INTR_STATUS      32'h0000_0014
`define MCI_REG_ERROR_FATAL_MASK 32'h0000_0018
`define MCI_REG_GENERIC_OUT      32'h0000_001C
`define MCI_REG_RESET_VECTOR     32'h0000_0020

`endif

// File: hdl/mci_pkg.sv
// MCI shared types
`include "mci_defs.svh"

package mci_pkg;

    // Single-beat request from the fabric
    typedef struct packed {
        logic [`MCI_ADDR_W-1:0] addr;
        logic [`MCI_DATA_W-1:0] wdata;
        logic [`MCI_USER_W-1:0] user;
        logic                   write;
    } mci_req_t;

    typedef struct packed {
        logic [`MCI_DATA_W-1:0] rdata;
        logic                   error;
    } mci_resp_t;

    // Requester class derived from the user ID
    typedef enum logic [1:0] {
        PRIV_NONE,
        PRIV_MCU,
        PRIV_CPTRA,
        PRIV_DEBUG
    } mci_priv_e;

    typedef struct packed {
        logic [`MCI_USER_W-1:0] mcu_user;
        logic [`MCI_USER_W-1:0] cptra_user;
        logic [`MCI_USER_W-1:0] debug_user;
    } mci_straps_t;

    // One index per mapped offset and REG_NONE for anything else
    typedef enum logic [3:0] {
        REG_BOOT_GO,
        REG_RESET_REQUEST,
        REG_WDT_EN,
        REG_WDT_RESTART,
        REG_WDT_PERIOD,
        REG_INTR_STATUS,
        REG_ERROR_FATAL_MASK,
        REG_GENERIC_OUT,
        REG_RESET_VECTOR,
        REG_NONE
    } mci_reg_e;

    typedef struct packed {
        mci_reg_e               idx;
        logic [`MCI_DATA_W-1:0] wdata;
        logic                   write;
        logic                   read;
        logic                   error;
    } mci_dec_t;

    typedef struct packed {
        logic        en;
        logic        restart;
        logic [31:0] period;
    } mci_wdt_cfg_t;

    typedef enum logic [2:0] {
        BOOT_RESET,
        BOOT_LCC_INIT,
        BOOT_FUSE_INIT,
        BOOT_WAIT_GO,
        BOOT_RUN
    } mci_boot_e;

endpackage

// File: hdl/mci_req_decode.sv
// MCI request decode
`include "mci_defs.svh"

module mci_req_decode (
    input  logic                 req_dv_i,
    input  mci_pkg::mci_req_t    req_i,
    input  mci_pkg::mci_straps_t straps_i,
    output logic                 dec_valid_o,
    output mci_pkg::mci_dec_t    dec_o
);
    import mci_pkg::*;

    mci_priv_e priv;
    mci_reg_e  reg_idx;
    logic      unmapped;
    logic      denied;
    logic      error;

    // Requester class from the strapped user IDs
    always_comb begin
        if (req_i.user == straps_i.mcu_user)
            priv = PRIV_MCU;
        else if (req_i.user == straps_i.cptra_user)
            priv = PRIV_CPTRA;
        else if (req_i.user == straps_i.debug_user)
            priv = PRIV_DEBUG;
        else
            priv = PRIV_NONE;
    end

    always_comb begin
        case (req_i.addr)
            `MCI_REG_BOOT_GO:          reg_idx = REG_BOOT_GO;
            `MCI_REG_RESET_REQUEST:    reg_idx = REG_RESET_REQUEST;
            `MCI_REG_WDT_EN:           reg_idx = REG_WDT_EN;
            `MCI_REG_WDT_RESTART:      reg_idx = REG_WDT_RESTART;
            `MCI_REG_WDT_PERIOD:       reg_idx = REG_WDT_PERIOD;
            `MCI_REG_INTR_STATUS:      reg_idx = REG_INTR_STATUS;
            `MCI_REG_ERROR_FATAL_MASK: reg_idx = REG_ERROR_FATAL_MASK;
            `MCI_REG_GENERIC_OUT:      reg_idx = REG_GENERIC_OUT;
            `MCI_REG_RESET_VECTOR:     reg_idx = REG_RESET_VECTOR;
            default:                   reg_idx = REG_NONE;
        endcase
    end

    assign unmapped = (reg_idx == REG_NONE);

    // Caliptra may read anything but only write BOOT_GO
    assign denied = (priv == PRIV_NONE) ||
                    ((priv == PRIV_CPTRA) && req_i.write && (reg_idx != REG_BOOT_GO));
    assign error  = unmapped | denied;

    assign dec_valid_o = req_dv_i;
    assign dec_o.idx   = reg_idx;
    assign dec_o.wdata = req_i.wdata;
    assign dec_o.write = req_i.write & ~error;
    assign dec_o.read  = ~req_i.write & ~error;
    assign dec_o.error = error;

endmodule

// File: hdl/mci_resp_gen.sv
// MCI response and error aggregation
`include "mci_defs.svh"

module mci_resp_gen (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   dec_valid_i,
    input  logic [`MCI_DATA_W-1:0] rdata_i,
    input  logic                   err_i,
    input  logic [31:0]            agg_error_fatal_i,
    input  logic [31:0]            agg_error_non_fatal_i,
    input  logic [31:0]            fatal_mask_i,
    output logic                   resp_valid_o,
    output mci_pkg::mci_resp_t     resp_o,
    output logic                   all_error_fatal_o,
    output logic                   all_error_non_fatal_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            resp_valid_o          <= 1'b0;
            all_error_fatal_o     <= 1'b0;
            all_error_non_fatal_o <= 1'b0;
        end else begin
            resp_valid_o          <= dec_valid_i;
            // Set mask bits hide the matching fatal sources
            all_error_fatal_o     <= |(agg_error_fatal_i & ~fatal_mask_i);
            all_error_non_fatal_o <= |agg_error_non_fatal_i;
        end
    end

    // Response payload captured only for accepted requests
    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            resp_o.rdata <= rdata_i;
            resp_o.error <= err_i;
        end
    end

endmodule

// File: hdl/mci_top.sv
// MCI register slice top level
`include "mci_defs.svh"

module mci_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   req_dv_i,
    input  mci_pkg::mci_req_t      req_i,
    input  mci_pkg::mci_straps_t   straps_i,
    input  logic [`MCI_DATA_W-1:0] strap_reset_vector_i,
    output logic                   resp_valid_o,
    output mci_pkg::mci_resp_t     resp_o,
    input  logic                   lc_done_i,
    output logic                   lc_init_o,
    input  logic                   fc_opt_done_i,
    output logic                   fc_opt_init_o,
    output logic                   cptra_rst_b_o,
    output logic                   mcu_rst_b_o,
    output mci_pkg::mci_boot_e     boot_fsm_o,
    output logic                   nmi_intr_o,
    output logic                   mci_intr_o,
    input  logic [31:0]            agg_error_fatal_i,
    input  logic [31:0]            agg_error_non_fatal_i,
    output logic                   all_error_fatal_o,
    output logic                   all_error_non_fatal_o,
    output logic [31:0]            generic_out_o,
    output logic [`MCI_DATA_W-1:0] mcu_reset_vector_o
);
    import mci_pkg::*;

    logic                   dec_valid;
    mci_dec_t               dec;
    logic [`MCI_DATA_W-1:0] rdata;
    logic                   err;
    mci_wdt_cfg_t           wdt_cfg;
    logic                   t1_timeout_p;
    logic                   boot_go;
    logic                   mcu_rst_req;
    logic [31:0]            fatal_mask;

    // Decode stage
    mci_req_decode i_req_decode (
        .req_dv_i    (req_dv_i),
        .req_i       (req_i),
        .straps_i    (straps_i),
        .dec_valid_o (dec_valid),
        .dec_o       (dec)
    );

    // Execute stage
    mci_csr_bank i_csr_bank (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .dec_valid_i          (dec_valid),
        .dec_i                (dec),
        .strap_reset_vector_i (strap_reset_vector_i),
        .t1_timeout_p_i       (t1_timeout_p),
        .rdata_o              (rdata),
        .err_o                (err),
        .wdt_cfg_o            (wdt_cfg),
        .boot_go_o            (boot_go),
        .mcu_rst_req_o        (mcu_rst_req),
        .fatal_mask_o         (fatal_mask),
        .generic_out_o        (generic_out_o),
        .mcu_reset_vector_o   (mcu_reset_vector_o),
        .mci_intr_o           (mci_intr_o)
    );

    mci_wdt i_wdt (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .cfg_i          (wdt_cfg),
        .t1_timeout_p_o (t1_timeout_p),
        .nmi_intr_o     (nmi_intr_o)
    );

    mci_boot_seqr i_boot_seqr (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .lc_done_i     (lc_done_i),
        .fc_opt_done_i (fc_opt_done_i),
        .boot_go_i     (boot_go),
        .mcu_rst_req_i (mcu_rst_req),
        .lc_init_o     (lc_init_o),
        .fc_opt_init_o (fc_opt_init_o),
        .cptra_rst_b_o (cptra_rst_b_o),
        .mcu_rst_b_o   (mcu_rst_b_o),
        .boot_fsm_o    (boot_fsm_o)
    );

    // Result stage
    mci_resp_gen i_resp_gen (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .dec_valid_i           (dec_valid),
        .rdata_i               (rdata),
        .err_i                 (err),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .fatal_mask_i          (fatal_mask),
        .resp_valid_o          (resp_valid_o),
        .resp_o                (resp_o),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o)
    );

endmodule

// File: hdl/mci_wdt.sv
// MCI two-stage watchdog
module mci_wdt (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  mci_pkg::mci_wdt_cfg_t cfg_i,
    output logic                  t1_timeout_p_o,
    output logic                  nmi_intr_o
);

    logic [31:0] count_q;
    logic        pending_q;
    logic        expire;

    // Period of zero keeps the timer from ever firing
    assign expire = cfg_i.en && (cfg_i.period != '0) &&
                    (count_q >= cfg_i.period - 32'd1);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q        <= '0;
            pending_q      <= 1'b0;
            t1_timeout_p_o <= 1'b0;
            nmi_intr_o     <= 1'b0;
        end else begin
            t1_timeout_p_o <= expire & ~cfg_i.restart;
            if (cfg_i.restart) begin
                count_q   <= '0;
                pending_q <= 1'b0;
            end else if (expire) begin
                count_q   <= '0;
                pending_q <= 1'b1;
                // Second expiry with the first one unserviced
                if (pending_q)
                    nmi_intr_o <= 1'b1;
            end else if (cfg_i.en) begin
                count_q <= count_q + 32'd1;
            end else begin
                count_q <= '0;
            end
        end
    end

endmodule

// File: list.f
+incdir+hdl
+incdir+bench
hdl/mci_pkg.sv
hdl/mci_req_decode.sv
hdl/mci_csr_bank.sv
hdl/mci_wdt.sv
hdl/mci_boot_seqr.sv
hdl/mci_resp_gen.sv
hdl/mci_top.sv
bench/mci_tb.sv
